// File: fpu_excpt_report.sv
// masks the raised flags with the control-word enables and retires the exception code
`timescale 1ns/1ns

module fpu_excpt_report (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           load_raise,
  input  logic [fpu_pkg::FLAG_W-1:0]     raise,
  input  logic [fpu_pkg::FPCSR_W-1:0]    fpcsr,
  fpu_op_if.exe                          ctl,
  output logic                           exc_en,
  output logic [fpu_pkg::EXC_CODE_W-1:0] exc_code
);

  logic [fpu_pkg::FLAG_W-1:0] raise_s1;
  logic [fpu_pkg::FLAG_W-1:0] masked;

  // lowest set flag wins, zero when nothing is set
  function automatic logic [fpu_pkg::EXC_CODE_W-1:0] lowest_set(
    input logic [fpu_pkg::FLAG_W-1:0] f
  );
    logic [fpu_pkg::EXC_CODE_W-1:0] idx;
    idx = '0;
    for (int i = fpu_pkg::FLAG_W - 1; i >= 0; i--) begin
      if (f[i]) begin
        idx = fpu_pkg::EXC_CODE_W'(i);
      end
    end
    return idx;
  endfunction

  always_ff @(posedge clk) begin
    if (load_raise) begin
      raise_s1 <= raise;
    end
  end

  assign masked = raise_s1 & fpcsr[fpu_pkg::FPCSR_EN_LSB +: fpu_pkg::FLAG_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      exc_en <= 1'b0;
      exc_code <= '0;
    end else if (ctl.s2_load) begin
      exc_en <= |masked;
      exc_code <= lowest_set(masked);
    end
  end

endmodule

// File: fpu_issue_ctrl.sv
// two-stage pipeline control: valid bits, stall, op decode at acceptance and the tag pipeline
`timescale 1ns/1ns

module fpu_issue_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  fpu_pkg::fpu_op_e          op,
  input  fpu_pkg::perm_mod_t        mod,
  input  logic [fpu_pkg::TAG_W-1:0] tag,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [fpu_pkg::TAG_W-1:0] res_tag,
  fpu_op_if.ctrl                    ctl
);

  logic s1_valid;
  logic s2_valid;
  logic stall;
  logic accept;
  logic s2_load;
  fpu_pkg::dec_op_t s1_op_q;
  logic [fpu_pkg::TAG_W-1:0] s1_tag;

  function automatic fpu_pkg::dec_op_t decode_op(input fpu_pkg::fpu_op_e code,
                                                 input fpu_pkg::perm_mod_t m);
    fpu_pkg::dec_op_t d;
    d = '0;
    case (code)
      fpu_pkg::OP_AND: begin
        d.is_logic = 1'b1;
        d.logic_sel = 2'd0;
      end
      fpu_pkg::OP_OR: begin
        d.is_logic = 1'b1;
        d.logic_sel = 2'd1;
      end
      fpu_pkg::OP_XOR: begin
        d.is_logic = 1'b1;
        d.logic_sel = 2'd2;
      end
      fpu_pkg::OP_ANDN: begin
        d.is_logic = 1'b1;
        d.logic_sel = 2'd3;
      end
      fpu_pkg::OP_PERM: begin
        d.is_perm = 1'b1;
        d.perm = m;
      end
      // unused codes leave everything clear and retire a zero
      default: d = '0;
    endcase
    return d;
  endfunction

  // stage 2 full and the consumer not taking it
  assign stall = s2_valid & ~out_ready;
  assign in_ready = ~stall;
  assign accept = in_valid & in_ready;
  assign s2_load = s1_valid & ~stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s1_op_q <= '0;
    end else begin
      s1_valid <= accept | (s1_valid & stall);
      if (!stall) begin
        s2_valid <= s1_valid;
      end
      if (accept) begin
        s1_op_q <= decode_op(op, mod);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_tag <= tag;
    end
    if (s2_load) begin
      res_tag <= s1_tag;
    end
  end

  assign out_valid = s2_valid;
  assign ctl.s1_load = accept;
  assign ctl.s2_load = s2_load;
  assign ctl.s1_op = s1_op_q;

endmodule

// File: fpu_op_if.sv
// decoded controls and stage enables passed from the issue control to the datapath blocks
`timescale 1ns/1ns

interface fpu_op_if;

  // stage-1 operand capture, same as input acceptance
  logic s1_load;
  // stage-2 result capture
  logic s2_load;
  // decoded operation held in stage 1
  fpu_pkg::dec_op_t s1_op;

  modport ctrl (
    output s1_load,
    output s2_load,
    output s1_op
  );

  modport exe (
    input s1_load,
    input s2_load,
    input s1_op
  );

endinterface

// File: fpu_perm_logic.sv
// stage-2 execution of bitwise logic and single-precision half permutes on the stage-1 operands
`timescale 1ns/1ns

module fpu_perm_logic #(
  parameter int DATA_W = fpu_pkg::DATA_W
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  fpu_op_if.exe             ctl,
  output logic [DATA_W-1:0] res
);

  localparam int HALF = DATA_W / 2;

  logic [DATA_W-1:0] logic_res;
  logic [DATA_W-1:0] perm_src;
  logic [DATA_W-1:0] perm_swp;
  logic [DATA_W-1:0] perm_res;
  logic [DATA_W-1:0] next_res;

  always_comb begin
    case (ctl.s1_op.logic_sel)
      2'd0: logic_res = a & b;
      2'd1: logic_res = a | b;
      2'd2: logic_res = a ^ b;
      default: logic_res = a & ~b;
    endcase
  end

  // swap first, then duplicate the low half
  assign perm_src = ctl.s1_op.perm.copy_a ? a : b;
  assign perm_swp = ctl.s1_op.perm.swap ? {perm_src[HALF-1:0], perm_src[DATA_W-1:HALF]}
                                        : perm_src;
  assign perm_res = ctl.s1_op.perm.dup ? {perm_swp[HALF-1:0], perm_swp[HALF-1:0]}
                                       : perm_swp;

  always_comb begin
    if (ctl.s1_op.is_logic) begin
      next_res = logic_res;
    end else if (ctl.s1_op.is_perm) begin
      next_res = perm_res;
    end else begin
      next_res = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res <= '0;
    end else if (ctl.s2_load) begin
      res <= next_res;
    end
  end

endmodule

// File: fpu_pkg.sv
// shared widths, operation codes, control-word fields and decoded-op types for the vector unit
package fpu_pkg;

  // datapath sizing
  localparam int DATA_W = 64;
  localparam int HALF_W = DATA_W / 2;
  localparam int NUM_FWD = 4;

  // 0 picks the issue operand, k picks result bus k-1
  localparam int FWD_SEL_W = 3;

  // exception flags and floating-point control word
  localparam int FLAG_W = 11;
  localparam int FPCSR_W = 32;
  // enable bits sit at 21:11
  localparam int FPCSR_EN_LSB = 11;
  localparam int EXC_CODE_W = 4;

  // functional-unit slot joined to execution index
  localparam int TAG_W = 9;

  typedef enum logic [3:0] {
    OP_AND = 4'd0,
    OP_OR = 4'd1,
    OP_XOR = 4'd2,
    OP_ANDN = 4'd3,
    OP_PERM = 4'd4
  } fpu_op_e;

  // dup is applied after swap
  typedef struct packed {
    logic copy_a;
    logic swap;
    logic dup;
  } perm_mod_t;

  typedef struct packed {
    logic is_logic;
    logic [1:0] logic_sel;
    logic is_perm;
    perm_mod_t perm;
  } dec_op_t;

endpackage

// File: fpu_unit.sv
// single-lane vector unit top: forwarding, logic/permute execution and exception retire
`timescale 1ns/1ns

module fpu_unit #(
  parameter int DATA_W = fpu_pkg::DATA_W,
  parameter int NUM_FWD = fpu_pkg::NUM_FWD
) (
  input  logic                           clk,
  input  logic                           rst,
  // issue side
  input  logic                           in_valid,
  output logic                           in_ready,
  input  fpu_pkg::fpu_op_e               op,
  input  fpu_pkg::perm_mod_t             mod,
  input  logic [DATA_W-1:0]              a,
  input  logic [DATA_W-1:0]              b,
  input  logic [fpu_pkg::FWD_SEL_W-1:0]  sel_a,
  input  logic [fpu_pkg::FWD_SEL_W-1:0]  sel_b,
  input  logic                           late_a,
  input  logic                           late_b,
  input  logic [fpu_pkg::FLAG_W-1:0]     raise,
  input  logic [fpu_pkg::TAG_W-1:0]      tag,
  // result buses and control word
  input  logic [NUM_FWD-1:0][DATA_W-1:0] fwd_bus,
  input  logic [fpu_pkg::FPCSR_W-1:0]    fpcsr,
  // result side
  output logic                           out_valid,
  input  logic                           out_ready,
  output logic [DATA_W-1:0]              res,
  output logic [fpu_pkg::TAG_W-1:0]      res_tag,
  output logic                           exc_en,
  output logic [fpu_pkg::EXC_CODE_W-1:0] exc_code
);

  fpu_op_if op_if ();

  logic [DATA_W-1:0] opnd_a;
  logic [DATA_W-1:0] opnd_b;

  fpu_issue_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .op        (op),
    .mod       (mod),
    .tag       (tag),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .res_tag   (res_tag),
    .ctl       (op_if.ctrl)
  );

  // operands load on the same acceptance as the op
  fwd_operand_mux #(.DATA_W(DATA_W), .NUM_FWD(NUM_FWD)) u_fwd_a (
    .clk       (clk),
    .rst       (rst),
    .load      (op_if.s1_load),
    .issue_val (a),
    .sel       (sel_a),
    .late      (late_a),
    .fwd_bus   (fwd_bus),
    .opnd      (opnd_a)
  );

  fwd_operand_mux #(.DATA_W(DATA_W), .NUM_FWD(NUM_FWD)) u_fwd_b (
    .clk       (clk),
    .rst       (rst),
    .load      (op_if.s1_load),
    .issue_val (b),
    .sel       (sel_b),
    .late      (late_b),
    .fwd_bus   (fwd_bus),
    .opnd      (opnd_b)
  );

  fpu_perm_logic #(.DATA_W(DATA_W)) u_exec (
    .clk (clk),
    .rst (rst),
    .a   (opnd_a),
    .b   (opnd_b),
    .ctl (op_if.exe),
    .res (res)
  );

  fpu_excpt_report u_excpt (
    .clk        (clk),
    .rst        (rst),
    .load_raise (op_if.s1_load),
    .raise      (raise),
    .fpcsr      (fpcsr),
    .ctl        (op_if.exe),
    .exc_en     (exc_en),
    .exc_code   (exc_code)
  );

endmodule

// File: fwd_operand_mux.sv
// picks one source operand from the issue value or a current / one-cycle-old result bus
`timescale 1ns/1ns

module fwd_operand_mux #(
  parameter int DATA_W = fpu_pkg::DATA_W,
  parameter int NUM_FWD = fpu_pkg::NUM_FWD
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  load,
  input  logic [DATA_W-1:0]                     issue_val,
  input  logic [fpu_pkg::FWD_SEL_W-1:0]         sel,
  input  logic                                  late,
  input  logic [NUM_FWD-1:0][DATA_W-1:0]        fwd_bus,
  output logic [DATA_W-1:0]                     opnd
);

  // bus values from the previous edge, sampled even while stalled
  logic [NUM_FWD-1:0][DATA_W-1:0] bus_prev;
  logic [DATA_W-1:0] pick;

  always_ff @(posedge clk) begin
    bus_prev <= fwd_bus;
  end

  always_comb begin
    // selects past the last bus give zero
    pick = '0;
    if (sel == '0) begin
      pick = issue_val;
    end
    for (int k = 0; k < NUM_FWD; k++) begin
      if (sel == fpu_pkg::FWD_SEL_W'(k + 1)) begin
        pick = late ? bus_prev[k] : fwd_bus[k];
      end
    end
  end

  // this is the stage-1 operand register
  always_ff @(posedge clk) begin
    if (rst) begin
      opnd <= '0;
    end else if (load) begin
      opnd <= pick;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
verilator --binary --timing --top-module tb_fpu_unit -f src.f -o sim_tb > build.log 2>&1 &&
  ./obj_dir/sim_tb > sim.log 2>&1 ||
  { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

// File: src.f
fpu_pkg.sv
fpu_op_if.sv
fwd_operand_mux.sv
fpu_issue_ctrl.sv
fpu_perm_logic.sv
fpu_excpt_report.sv
fpu_unit.sv
tb_fpu_checker.sv
tb_fpu_unit.sv

// File: tb_fpu_checker.sv
// scoreboard for the vector unit testbench: follows the DUT handshake, predicts results, counts errors
`timescale 1ns/1ns

module tb_fpu_checker (
  input logic                                                   clk,
  input logic                                                   rst,
  input logic                                                   in_valid,
  input logic                                                   in_ready,
  input fpu_pkg::fpu_op_e                                       op,
  input fpu_pkg::perm_mod_t                                     mod,
  input logic [fpu_pkg::DATA_W-1:0]                             a,
  input logic [fpu_pkg::DATA_W-1:0]                             b,
  input logic [fpu_pkg::FWD_SEL_W-1:0]                          sel_a,
  input logic [fpu_pkg::FWD_SEL_W-1:0]                          sel_b,
  input logic                                                   late_a,
  input logic                                                   late_b,
  input logic [fpu_pkg::FLAG_W-1:0]                             raise,
  input logic [fpu_pkg::TAG_W-1:0]                              tag,
  input logic [fpu_pkg::NUM_FWD-1:0][fpu_pkg::DATA_W-1:0]       fwd_bus,
  input logic [fpu_pkg::FPCSR_W-1:0]                            fpcsr,
  input logic                                                   out_valid,
  input logic                                                   out_ready,
  input logic [fpu_pkg::DATA_W-1:0]                             res,
  input logic [fpu_pkg::TAG_W-1:0]                              res_tag,
  input logic                                                   exc_en,
  input logic [fpu_pkg::EXC_CODE_W-1:0]                         exc_code
);

  localparam int DATA_W = fpu_pkg::DATA_W;
  localparam int HALF_W = fpu_pkg::HALF_W;

  typedef struct packed {
    logic [DATA_W-1:0] res;
    logic [fpu_pkg::TAG_W-1:0] tag;
    logic [fpu_pkg::FLAG_W-1:0] raise;
    logic en;
    logic [fpu_pkg::EXC_CODE_W-1:0] code;
  } exp_t;

  // s1q mirrors stage 1, exp_q mirrors stage 2
  exp_t s1q[$];
  exp_t exp_q[$];
  exp_t e;
  logic [fpu_pkg::NUM_FWD-1:0][DATA_W-1:0] bus_prev;
  logic [DATA_W+fpu_pkg::TAG_W+fpu_pkg::EXC_CODE_W:0] held_out;
  logic held_valid = 1'b0;
  logic rst_d = 1'b0;
  logic stall;
  int val_errs = 0;
  int seq_errs = 0;
  int pending = 0;

  function automatic logic [DATA_W-1:0] operand(input logic [fpu_pkg::FWD_SEL_W-1:0] s,
                                                input logic lt,
                                                input logic [DATA_W-1:0] issue);
    if (s == 0) begin
      return issue;
    end
    if (int'(s) > fpu_pkg::NUM_FWD) begin
      return '0;
    end
    return lt ? bus_prev[s - 3'd1] : fwd_bus[s - 3'd1];
  endfunction

  function automatic logic [DATA_W-1:0] expected_res(input fpu_pkg::fpu_op_e o,
                                                     input fpu_pkg::perm_mod_t m,
                                                     input logic [DATA_W-1:0] x,
                                                     input logic [DATA_W-1:0] y);
    logic [HALF_W-1:0] hi;
    logic [HALF_W-1:0] lo;
    logic [HALF_W-1:0] t;
    case (o)
      fpu_pkg::OP_AND: return x & y;
      fpu_pkg::OP_OR: return x | y;
      fpu_pkg::OP_XOR: return x ^ y;
      fpu_pkg::OP_ANDN: return x & ~y;
      fpu_pkg::OP_PERM: begin
        {hi, lo} = m.copy_a ? x : y;
        if (m.swap) begin
          t = hi;
          hi = lo;
          lo = t;
        end
        // dup sees the already swapped halves
        if (m.dup) begin
          hi = lo;
        end
        return {hi, lo};
      end
      default: return '0;
    endcase
  endfunction

  // enables are taken from the control word at the stage-2 step
  function automatic exp_t retire_exc(input exp_t x);
    logic [fpu_pkg::FLAG_W-1:0] m;
    m = x.raise & fpcsr[fpu_pkg::FPCSR_EN_LSB +: fpu_pkg::FLAG_W];
    x.en = 1'b0;
    x.code = '0;
    for (int i = 0; i < fpu_pkg::FLAG_W; i++) begin
      if (m[i] && !x.en) begin
        x.code = fpu_pkg::EXC_CODE_W'(i);
        x.en = 1'b1;
      end
    end
    return x;
  endfunction

  always @(posedge clk) begin
    if (rst_d && (out_valid !== 1'b0 || exc_en !== 1'b0)) begin
      $display("FAIL %0t: out_valid %b exc_en %b around reset", $time, out_valid, exc_en);
      val_errs++;
    end
    if (rst) begin
      s1q.delete();
      exp_q.delete();
      held_valid = 1'b0;
    end else begin
      stall = (exp_q.size() != 0) && !out_ready;
      if (out_valid !== (exp_q.size() != 0)) begin
        $display("FAIL %0t: out_valid %b with %0d results due", $time, out_valid, exp_q.size());
        val_errs++;
      end
      if (in_ready !== !stall) begin
        $display("FAIL %0t: in_ready %b while stall is %b", $time, in_ready, stall);
        val_errs++;
      end
      if (held_valid && out_valid && {res, res_tag, exc_en, exc_code} !== held_out) begin
        $display("FAIL %0t: result outputs changed while out_ready was low", $time);
        val_errs++;
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("extra result with tag %0d came out with no request behind it", res_tag);
          seq_errs++;
        end else begin
          e = exp_q.pop_front();
          if ({res, res_tag, exc_en, exc_code} !== {e.res, e.tag, e.en, e.code}) begin
            $display("FAIL %0t: got res %h tag %0d exc %b/%0d, expected res %h tag %0d exc %b/%0d",
                     $time, res, res_tag, exc_en, exc_code, e.res, e.tag, e.en, e.code);
            val_errs++;
          end
        end
      end
      held_valid = out_valid && !out_ready;
      held_out = {res, res_tag, exc_en, exc_code};
      if (s1q.size() != 0 && !stall) begin
        exp_q.push_back(retire_exc(s1q.pop_front()));
      end
      if (in_valid && in_ready) begin
        e = '0;
        e.res = expected_res(op, mod, operand(sel_a, late_a, a), operand(sel_b, late_b, b));
        e.tag = tag;
        e.raise = raise;
        s1q.push_back(e);
      end
    end
    bus_prev = fwd_bus;
    rst_d = rst;
    pending <= s1q.size() + exp_q.size();
  end

endmodule

// File: tb_fpu_unit.sv
// testbench top for the vector unit: clock, reset, stimulus table through the handshake, watchdog
`timescale 1ns/1ns

module tb_fpu_unit;

  localparam int NUM_ROWS = 16;

  typedef struct packed {
    fpu_pkg::fpu_op_e op;
    fpu_pkg::perm_mod_t mod;
    logic [fpu_pkg::FWD_SEL_W-1:0] sel_a;
    logic late_a;
    logic [fpu_pkg::FWD_SEL_W-1:0] sel_b;
    logic late_b;
    logic [fpu_pkg::FLAG_W-1:0] raise;
    logic [fpu_pkg::FLAG_W-1:0] en;
    logic [7:0] stall;
  } row_t;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic in_valid = 1'b0;
  logic in_ready;
  fpu_pkg::fpu_op_e op = fpu_pkg::OP_AND;
  fpu_pkg::perm_mod_t mod = '0;
  logic [fpu_pkg::DATA_W-1:0] a = '0;
  logic [fpu_pkg::DATA_W-1:0] b = '0;
  logic [fpu_pkg::FWD_SEL_W-1:0] sel_a = '0;
  logic [fpu_pkg::FWD_SEL_W-1:0] sel_b = '0;
  logic late_a = 1'b0;
  logic late_b = 1'b0;
  logic [fpu_pkg::FLAG_W-1:0] raise = '0;
  logic [fpu_pkg::TAG_W-1:0] tag = '0;
  logic [fpu_pkg::NUM_FWD-1:0][fpu_pkg::DATA_W-1:0] fwd_bus = '0;
  logic [fpu_pkg::FPCSR_W-1:0] fpcsr = '0;
  logic out_valid;
  logic out_ready = 1'b1;
  logic [fpu_pkg::DATA_W-1:0] res;
  logic [fpu_pkg::TAG_W-1:0] res_tag;
  logic exc_en;
  logic [fpu_pkg::EXC_CODE_W-1:0] exc_code;
  logic [31:0] lfsr = 32'h543d;
  logic [7:0] stall_pat = '0;
  logic [2:0] cyc = '0;
  row_t rows [NUM_ROWS];

  fpu_unit #(.DATA_W(fpu_pkg::DATA_W), .NUM_FWD(fpu_pkg::NUM_FWD)) dut (.*);

  tb_fpu_checker chk (.*);

  // taps 32, 22, 2, 1; one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[62:0], fb};
    end
    return r;
  endfunction

  always #20 clk = ~clk;

  // buses change every cycle, out_ready follows the row's stall pattern
  always @(posedge clk) begin
    cyc <= cyc + 3'd1;
    out_ready <= ~stall_pat[cyc];
    for (int k = 0; k < fpu_pkg::NUM_FWD; k++) begin
      fwd_bus[k] <= rand_bits(64);
    end
  end

  initial begin
    // op, mod, sel_a, late_a, sel_b, late_b, raise, enables, stall pattern
    rows[0] = '{fpu_pkg::OP_AND, 3'b000, 3'd0, 1'b0, 3'd0, 1'b0, 11'h000, 11'h7ff, 8'h00};
    rows[1] = '{fpu_pkg::OP_OR, 3'b000, 3'd1, 1'b0, 3'd2, 1'b0, 11'h001, 11'h7ff, 8'h00};
    rows[2] = '{fpu_pkg::OP_XOR, 3'b000, 3'd3, 1'b1, 3'd4, 1'b0, 11'h006, 11'h004, 8'h00};
    rows[3] = '{fpu_pkg::OP_ANDN, 3'b000, 3'd0, 1'b0, 3'd1, 1'b1, 11'h7ff, 11'h000, 8'h00};
    rows[4] = '{fpu_pkg::OP_PERM, 3'b000, 3'd2, 1'b1, 3'd0, 1'b0, 11'h400, 11'h7ff, 8'h00};
    rows[5] = '{fpu_pkg::OP_PERM, 3'b001, 3'd0, 1'b0, 3'd3, 1'b0, 11'h300, 11'h200, 8'hf0};
    rows[6] = '{fpu_pkg::OP_PERM, 3'b010, 3'd4, 1'b1, 3'd2, 1'b1, 11'h0a0, 11'h0f0, 8'h00};
    rows[7] = '{fpu_pkg::OP_PERM, 3'b011, 3'd0, 1'b0, 3'd0, 1'b0, 11'h008, 11'h7ff, 8'h5a};
    rows[8] = '{fpu_pkg::OP_PERM, 3'b100, 3'd1, 1'b1, 3'd4, 1'b1, 11'h7f0, 11'h010, 8'h00};
    rows[9] = '{fpu_pkg::OP_PERM, 3'b101, 3'd3, 1'b0, 3'd0, 1'b0, 11'h002, 11'h003, 8'hcc};
    rows[10] = '{fpu_pkg::OP_PERM, 3'b110, 3'd0, 1'b0, 3'd2, 1'b0, 11'h000, 11'h7ff, 8'h00};
    rows[11] = '{fpu_pkg::OP_PERM, 3'b111, 3'd4, 1'b0, 3'd1, 1'b0, 11'h180, 11'h100, 8'h3c};
    rows[12] = '{fpu_pkg::fpu_op_e'(4'd9), 3'b000, 3'd1, 1'b0, 3'd2, 1'b1, 11'h000, 11'h7ff,
                 8'h00};
    rows[13] = '{fpu_pkg::OP_XOR, 3'b000, 3'd4, 1'b1, 3'd4, 1'b0, 11'h555, 11'h2aa, 8'ha5};
    rows[14] = '{fpu_pkg::OP_AND, 3'b000, 3'd2, 1'b1, 3'd3, 1'b1, 11'h040, 11'h7ff, 8'h0f};
    rows[15] = '{fpu_pkg::OP_OR, 3'b000, 3'd0, 1'b0, 3'd0, 1'b0, 11'h7ff, 11'h7ff, 8'h00};
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      in_valid <= 1'b1;
      op <= rows[i].op;
      mod <= rows[i].mod;
      a <= rand_bits(64);
      b <= rand_bits(64);
      sel_a <= rows[i].sel_a;
      late_a <= rows[i].late_a;
      sel_b <= rows[i].sel_b;
      late_b <= rows[i].late_b;
      raise <= rows[i].raise;
      tag <= fpu_pkg::TAG_W'(i);
      stall_pat <= rows[i].stall;
      // hold the row until the DUT takes it
      @(posedge clk);
      while (!in_ready) @(posedge clk);
      // flags are masked when the row moves into stage 2
      fpcsr <= {10'(rand_bits(10)), rows[i].en, 11'(rand_bits(11))};
    end
    in_valid <= 1'b0;
    stall_pat <= '0;
    @(posedge clk);
    while (chk.pending != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    $display("errors: %0d wrong values, %0d lost or extra results", chk.val_errs, chk.seq_errs);
    if (chk.val_errs + chk.seq_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    repeat (NUM_ROWS * 20 + 200) @(posedge clk);
    $display("watchdog expired with %0d results still outstanding", chk.pending);
    $display("Regression failed");
    $finish;
  end

endmodule
